// ==== src/mspe_pkg.sv ====
`default_nettype none

package mspe_pkg;

    localparam int CSR_DATA_W   = 32;
    localparam int CSR_ADDR_W   = 5;
    localparam int DRAM_DATA_W  = 512;
    localparam int DRAM_ADDR_W  = 64;
    localparam int DRAM_BE_W    = 64;
    localparam int DRAM_BURST_W = 3;
    localparam int COUNTER_W    = 64;

    localparam logic [CSR_DATA_W-1:0] VERSION     = 32'h3434_0002;
    localparam logic [CSR_DATA_W-1:0] CSR_DEFAULT = 32'hDEAD_BEEF;

    // CSR word addresses
    localparam logic [CSR_ADDR_W-1:0] CSR_VERSION      = 5'd0;
    localparam logic [CSR_ADDR_W-1:0] CSR_STATUS       = 5'd2;
    localparam logic [CSR_ADDR_W-1:0] CSR_CONTROL      = 5'd3;
    localparam logic [CSR_ADDR_W-1:0] CSR_SRC_COUNT_HI = 5'd6;
    localparam logic [CSR_ADDR_W-1:0] CSR_SRC_COUNT_LO = 5'd7;
    localparam logic [CSR_ADDR_W-1:0] CSR_DRAM_KICK    = 5'd13;
    localparam logic [CSR_ADDR_W-1:0] CSR_DRAM_ADDR_HI = 5'd14;
    localparam logic [CSR_ADDR_W-1:0] CSR_DRAM_ADDR_LO = 5'd15;
    localparam logic [CSR_ADDR_W-1:0] CSR_WINDOW_BASE  = 5'd16;

    localparam int WINDOW_WORDS = 16; // first window address is the top slice

endpackage

`default_nettype wire

// ==== src/mspe_csr.sv ====
`timescale 1ns/10ps
`default_nettype none

module mspe_csr #(
    parameter int CORES = 4
) (
    input  wire                                    clk,
    input  wire                                    reset,
    input  wire [mspe_pkg::CSR_ADDR_W-1:0]         csr_address,
    input  wire [mspe_pkg::CSR_DATA_W-1:0]         csr_writedata,
    input  wire                                    csr_write,
    input  wire                                    csr_read,
    output logic [mspe_pkg::CSR_DATA_W-1:0]        csr_readdata,
    input  wire [CORES-1:0]                        core_halt,
    input  wire [mspe_pkg::COUNTER_W-1:0]          src_counter,
    input  wire [mspe_pkg::CSR_DATA_W-1:0]         read_slice,
    output logic                                   addr_hi_we,
    output logic                                   addr_lo_we,
    output logic                                   window_we,
    output logic [$clog2(mspe_pkg::WINDOW_WORDS)-1:0] window_index,
    output logic                                   kick_we,
    output logic [mspe_pkg::CSR_DATA_W-1:0]        write_word,
    output logic                                   all_core_reset,
    output logic                                   src_clear
);

    logic                            window_hit;
    logic [mspe_pkg::CSR_DATA_W-1:0] status_word;
    logic [mspe_pkg::CSR_DATA_W-1:0] control_word;

    assign window_hit   = (csr_address >= mspe_pkg::CSR_WINDOW_BASE);
    assign window_index = csr_address[$clog2(mspe_pkg::WINDOW_WORDS)-1:0];
    assign write_word   = csr_writedata;

    // bridge strobes
    assign addr_hi_we = csr_write && (csr_address == mspe_pkg::CSR_DRAM_ADDR_HI);
    assign addr_lo_we = csr_write && (csr_address == mspe_pkg::CSR_DRAM_ADDR_LO);
    assign kick_we    = csr_write && (csr_address == mspe_pkg::CSR_DRAM_KICK);
    assign window_we  = csr_write && window_hit;

    always_comb begin
        status_word = '0;
        status_word[CORES-1:0] = core_halt;
        control_word = '0;
        control_word[3] = all_core_reset;
        control_word[0] = src_clear;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            all_core_reset <= 1'b0;
            src_clear      <= 1'b0;
        end else if (csr_write && csr_address == mspe_pkg::CSR_CONTROL) begin
            all_core_reset <= csr_writedata[3];
            src_clear      <= csr_writedata[0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            csr_readdata <= '0;
        end else if (csr_read) begin
            case (csr_address)
                mspe_pkg::CSR_VERSION: begin
                    csr_readdata <= mspe_pkg::VERSION;
                end
                mspe_pkg::CSR_STATUS: begin
                    csr_readdata <= status_word;
                end
                mspe_pkg::CSR_CONTROL: begin
                    csr_readdata <= control_word;
                end
                mspe_pkg::CSR_SRC_COUNT_HI: begin
                    csr_readdata <= src_counter[mspe_pkg::COUNTER_W-1 -: mspe_pkg::CSR_DATA_W];
                end
                mspe_pkg::CSR_SRC_COUNT_LO: begin
                    csr_readdata <= src_counter[mspe_pkg::CSR_DATA_W-1:0];
                end
                default: begin
                    csr_readdata <= window_hit ? read_slice : mspe_pkg::CSR_DEFAULT;
                end
            endcase
        end
    end

    // host never issues read and write in one cycle
    assert property (@(posedge clk) disable iff (reset) !(csr_read && csr_write))
        else $error("csr read and write issued together");

endmodule

`default_nettype wire

// ==== src/mspe_dram_bridge.sv ====
`timescale 1ns/10ps
`default_nettype none

module mspe_dram_bridge (
    input  wire                                    clk,
    input  wire                                    reset,
    input  wire                                    addr_hi_we,
    input  wire                                    addr_lo_we,
    input  wire                                    window_we,
    input  wire [$clog2(mspe_pkg::WINDOW_WORDS)-1:0] window_index,
    input  wire                                    kick_we,
    input  wire [mspe_pkg::CSR_DATA_W-1:0]         write_word,
    output logic [mspe_pkg::CSR_DATA_W-1:0]        read_slice,
    input  wire                                    m0_waitrequest,
    input  wire [mspe_pkg::DRAM_DATA_W-1:0]        m0_readdata,
    input  wire                                    m0_readdatavalid,
    output logic [mspe_pkg::DRAM_ADDR_W-1:0]       m0_address,
    output logic [mspe_pkg::DRAM_DATA_W-1:0]       m0_writedata,
    output logic                                   m0_write,
    output logic                                   m0_read,
    output logic [mspe_pkg::DRAM_BURST_W-1:0]      m0_burstcount,
    output logic [mspe_pkg::DRAM_BE_W-1:0]         m0_byteenable,
    output logic                                   m0_debugaccess
);

    localparam int W = mspe_pkg::CSR_DATA_W;

    logic [1:0]                       kick;
    logic [1:0]                       kick_d;
    logic [1:0]                       kick_d2;
    logic [1:0]                       kick_rise;
    logic [mspe_pkg::DRAM_DATA_W-1:0] read_word;

    assign kick_rise      = kick_d & ~kick_d2; // bit 1 read, bit 0 write
    assign m0_burstcount  = {{(mspe_pkg::DRAM_BURST_W-1){1'b0}}, 1'b1};
    assign m0_byteenable  = '1;
    assign m0_debugaccess = 1'b0;
    assign read_slice     = read_word[(mspe_pkg::WINDOW_WORDS-1-window_index)*W +: W];

    always_ff @(posedge clk) begin
        if (addr_hi_we)
            m0_address[mspe_pkg::DRAM_ADDR_W-1 -: W] <= write_word;
        if (addr_lo_we)
            m0_address[W-1:0] <= write_word;
        if (window_we)
            m0_writedata[(mspe_pkg::WINDOW_WORDS-1-window_index)*W +: W] <= write_word;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            kick     <= '0;
            kick_d   <= '0;
            kick_d2  <= '0;
            m0_write <= 1'b0;
            m0_read  <= 1'b0;
        end else begin
            if (kick_we)
                kick <= write_word[1:0];
            kick_d  <= kick;  // extra stage before edge detect
            kick_d2 <= kick_d;
            if (kick_rise[0])
                m0_write <= 1'b1;
            else if (!m0_waitrequest)
                m0_write <= 1'b0; // accepted
            if (kick_rise[1])
                m0_read <= 1'b1;
            else if (!m0_waitrequest)
                m0_read <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            read_word <= '1;
        else if (m0_readdatavalid)
            read_word <= m0_readdata;
    end

    assert property (@(posedge clk) disable iff (reset) !(m0_read && m0_write))
        else $error("m0 read and write requested together");

endmodule

`default_nettype wire

// ==== src/mspe_core_queue.sv ====
`timescale 1ns/10ps
`default_nettype none

module mspe_core_queue #(
    parameter int CORES = 4,
    localparam int ID_W = (CORES > 1) ? $clog2(CORES) : 1
) (
    input  wire             clk,
    input  wire             flush,
    input  wire             push,
    input  wire [ID_W-1:0]  push_id,
    output logic [ID_W-1:0] head_id,
    output logic            head_valid,
    input  wire             pop
);

    localparam int CNT_W = $clog2(CORES + 1);

    logic [ID_W-1:0]  mem [CORES];
    logic [ID_W-1:0]  wr_ptr;
    logic [ID_W-1:0]  rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;

    function automatic logic [ID_W-1:0] next_ptr(input logic [ID_W-1:0] ptr);
        return (ptr == ID_W'(CORES - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full       = (count == CNT_W'(CORES));
    assign head_valid = (count != '0);
    assign head_id    = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push && !flush)
            mem[wr_ptr] <= push_id;
    end

    always_ff @(posedge clk) begin
        if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    // every core is queued at most once, so a full queue cannot take more
    assert property (@(posedge clk) disable iff (flush) push |-> (!full || pop))
        else $error("core queue push while full");
    assert property (@(posedge clk) disable iff (flush) pop |-> head_valid)
        else $error("core queue pop while empty");

endmodule

`default_nettype wire

// ==== src/mspe_core_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module mspe_core_sequencer #(
    parameter int CORES = 4,
    localparam int ID_W = (CORES > 1) ? $clog2(CORES) : 1
) (
    input  wire                                   clk,
    input  wire                                   reset,
    input  wire                                   all_core_reset,
    input  wire                                   load_done,
    input  wire [ID_W-1:0]                        load_core,
    output logic [CORES-1:0]                      core_run,
    output logic [CORES-1:0]                      core_reset,
    output logic [CORES-1:0]                      core_src_req,
    input  wire [CORES-1:0]                       core_halt,
    input  wire [CORES-1:0]                       core_src_valid,
    input  wire [CORES-1:0]                       core_src_sop,
    input  wire [CORES-1:0]                       core_src_eop,
    input  wire [CORES*mspe_pkg::DRAM_DATA_W-1:0] core_src_data,
    output logic                                  src_valid,
    output logic                                  src_sop,
    output logic                                  src_eop,
    output logic [mspe_pkg::DRAM_DATA_W-1:0]      src_data
);

    localparam int DW = mspe_pkg::DRAM_DATA_W;
    localparam logic [CORES-1:0] CORE_ONE = 1;

    logic            flush;
    logic [ID_W-1:0] head_id;
    logic            head_valid;
    logic            head_halt;
    logic            head_eop;
    logic            halt_d;
    logic            eop_d;
    logic            halt_rise;
    logic            pop;

    assign flush     = reset | all_core_reset;
    assign head_halt = head_valid & core_halt[head_id];
    assign head_eop  = head_valid & core_src_eop[head_id];
    assign halt_rise = head_halt & ~halt_d;
    assign pop       = head_eop & ~eop_d; // end of output releases the head

    mspe_core_queue #(
        .CORES(CORES)
    ) i_run_queue (
        .clk(clk),
        .flush(flush),
        .push(load_done),
        .push_id(load_core),
        .head_id(head_id),
        .head_valid(head_valid),
        .pop(pop)
    );

    always_ff @(posedge clk) begin
        if (flush) begin
            core_run     <= '0;
            core_src_req <= '0;
            core_reset   <= '1; // hold every core in reset
            halt_d       <= 1'b0;
            eop_d        <= 1'b0;
        end else begin
            core_run     <= load_done ? (CORE_ONE << load_core) : '0;
            core_src_req <= halt_rise ? (CORE_ONE << head_id) : '0;
            core_reset   <= pop ? (CORE_ONE << head_id) : '0;
            // new head starts from a low history so a halt already high counts
            halt_d <= head_halt & ~pop;
            eop_d  <= head_eop & ~pop;
        end
    end

    always_comb begin
        src_valid = head_valid & core_src_valid[head_id];
        src_sop   = head_valid & core_src_sop[head_id];
        src_eop   = head_eop;
        src_data  = head_valid ? core_src_data[head_id*DW +: DW] : '0;
    end

endmodule

`default_nettype wire

// ==== src/mspe_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module mspe_top #(
    parameter int CORES = 4,
    localparam int ID_W = (CORES > 1) ? $clog2(CORES) : 1
) (
    input  wire                                   clk,
    input  wire                                   reset,
    input  wire [mspe_pkg::CSR_ADDR_W-1:0]        csr_address,
    input  wire [mspe_pkg::CSR_DATA_W-1:0]        csr_writedata,
    input  wire                                   csr_write,
    input  wire                                   csr_read,
    output logic [mspe_pkg::CSR_DATA_W-1:0]       csr_readdata,
    input  wire                                   m0_waitrequest,
    input  wire [mspe_pkg::DRAM_DATA_W-1:0]       m0_readdata,
    input  wire                                   m0_readdatavalid,
    output logic [mspe_pkg::DRAM_ADDR_W-1:0]      m0_address,
    output logic [mspe_pkg::DRAM_DATA_W-1:0]      m0_writedata,
    output logic                                  m0_write,
    output logic                                  m0_read,
    output logic [mspe_pkg::DRAM_BURST_W-1:0]     m0_burstcount,
    output logic [mspe_pkg::DRAM_BE_W-1:0]        m0_byteenable,
    output logic                                  m0_debugaccess,
    input  wire [mspe_pkg::COUNTER_W-1:0]         src_counter,
    output logic                                  src_clear,
    input  wire                                   load_done,
    input  wire [ID_W-1:0]                        load_core,
    output logic [CORES-1:0]                      core_run,
    output logic [CORES-1:0]                      core_reset,
    output logic [CORES-1:0]                      core_src_req,
    input  wire [CORES-1:0]                       core_halt,
    input  wire [CORES-1:0]                       core_src_valid,
    input  wire [CORES-1:0]                       core_src_sop,
    input  wire [CORES-1:0]                       core_src_eop,
    input  wire [CORES*mspe_pkg::DRAM_DATA_W-1:0] core_src_data,
    output logic                                  src_valid,
    output logic                                  src_sop,
    output logic                                  src_eop,
    output logic [mspe_pkg::DRAM_DATA_W-1:0]      src_data
);

    logic [mspe_pkg::CSR_DATA_W-1:0]           read_slice;
    logic [mspe_pkg::CSR_DATA_W-1:0]           write_word;
    logic [$clog2(mspe_pkg::WINDOW_WORDS)-1:0] window_index;
    logic                                      addr_hi_we;
    logic                                      addr_lo_we;
    logic                                      window_we;
    logic                                      kick_we;
    logic                                      all_core_reset;

    mspe_csr #(
        .CORES(CORES)
    ) i_csr (
        .clk(clk), .reset(reset),
        .csr_address(csr_address), .csr_writedata(csr_writedata),
        .csr_write(csr_write), .csr_read(csr_read), .csr_readdata(csr_readdata),
        .core_halt(core_halt), .src_counter(src_counter), .read_slice(read_slice),
        .addr_hi_we(addr_hi_we), .addr_lo_we(addr_lo_we),
        .window_we(window_we), .window_index(window_index),
        .kick_we(kick_we), .write_word(write_word),
        .all_core_reset(all_core_reset), .src_clear(src_clear)
    );

    mspe_dram_bridge i_dram_bridge (
        .clk(clk), .reset(reset),
        .addr_hi_we(addr_hi_we), .addr_lo_we(addr_lo_we),
        .window_we(window_we), .window_index(window_index),
        .kick_we(kick_we), .write_word(write_word), .read_slice(read_slice),
        .m0_waitrequest(m0_waitrequest), .m0_readdata(m0_readdata),
        .m0_readdatavalid(m0_readdatavalid),
        .m0_address(m0_address), .m0_writedata(m0_writedata),
        .m0_write(m0_write), .m0_read(m0_read),
        .m0_burstcount(m0_burstcount), .m0_byteenable(m0_byteenable),
        .m0_debugaccess(m0_debugaccess)
    );

    mspe_core_sequencer #(
        .CORES(CORES)
    ) i_core_sequencer (
        .clk(clk), .reset(reset), .all_core_reset(all_core_reset),
        .load_done(load_done), .load_core(load_core),
        .core_run(core_run), .core_reset(core_reset), .core_src_req(core_src_req),
        .core_halt(core_halt), .core_src_valid(core_src_valid),
        .core_src_sop(core_src_sop), .core_src_eop(core_src_eop),
        .core_src_data(core_src_data),
        .src_valid(src_valid), .src_sop(src_sop), .src_eop(src_eop),
        .src_data(src_data)
    );

endmodule

`default_nettype wire

// ==== verif/tb_mspe.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_mspe;

    localparam int CORES      = 4;
    localparam int DW         = mspe_pkg::DRAM_DATA_W;
    localparam int MAX_CYCLES = 2000; // all five tests take a few hundred cycles

    logic                                  clk;
    logic                                  reset;
    logic [mspe_pkg::CSR_ADDR_W-1:0]       csr_address;
    logic [mspe_pkg::CSR_DATA_W-1:0]       csr_writedata;
    logic                                  csr_write;
    logic                                  csr_read;
    logic [mspe_pkg::CSR_DATA_W-1:0]       csr_readdata;
    logic                                  m0_waitrequest;
    logic [DW-1:0]                         m0_readdata;
    logic                                  m0_readdatavalid;
    logic [mspe_pkg::DRAM_ADDR_W-1:0]      m0_address;
    logic [DW-1:0]                         m0_writedata;
    logic                                  m0_write;
    logic                                  m0_read;
    logic [mspe_pkg::DRAM_BURST_W-1:0]     m0_burstcount;
    logic [mspe_pkg::DRAM_BE_W-1:0]        m0_byteenable;
    logic                                  m0_debugaccess;
    logic [mspe_pkg::COUNTER_W-1:0]        src_counter;
    logic                                  src_clear;
    logic                                  load_done;
    logic [1:0]                            load_core;
    logic [CORES-1:0]                      core_run;
    logic [CORES-1:0]                      core_reset;
    logic [CORES-1:0]                      core_src_req;
    logic [CORES-1:0]                      core_halt;
    logic [CORES-1:0]                      core_src_valid;
    logic [CORES-1:0]                      core_src_sop;
    logic [CORES-1:0]                      core_src_eop;
    logic [CORES*DW-1:0]                   core_src_data;
    logic                                  src_valid;
    logic                                  src_sop;
    logic                                  src_eop;
    logic [DW-1:0]                         src_data;

    logic [31:0] lfsr_state;
    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          cycles = 0;
    int          run_count [CORES];
    int          req_count [CORES];
    int          rst_count [CORES];

    mspe_top #(
        .CORES(CORES)
    ) i_mspe_top (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: tests still running after %0d cycles", MAX_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    // pulse counters per core, sampled mid cycle
    always @(negedge clk) begin
        for (int i = 0; i < CORES; i++) begin
            if (core_run[i])
                run_count[i]++;
            if (core_src_req[i])
                req_count[i]++;
            if (core_reset[i])
                rst_count[i]++;
        end
    end

    // galois lfsr, one step per bit
    function automatic logic [DW-1:0] rand_bits(input int n);
        logic [DW-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[DW-2:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
        end
        return v;
    endfunction

    task automatic expect_equal(input string what, input logic [DW-1:0] got,
                                input logic [DW-1:0] exp);
        checks++;
        assert (got === exp)
        else begin
            errors++;
            $display("ERROR at %0t ns: %s: got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic finish_test(input string name, input int start_errors);
        tests_run++;
        $display("%s: done, %0d errors", name, errors - start_errors);
    endtask

    task automatic clear_counts();
        for (int i = 0; i < CORES; i++) begin
            run_count[i] = 0;
            req_count[i] = 0;
            rst_count[i] = 0;
        end
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
    endtask

    // ends just after the write edge
    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        @(posedge clk);
        csr_address   <= addr;
        csr_writedata <= data;
        csr_write     <= 1'b1;
        @(posedge clk);
        csr_write <= 1'b0;
    endtask

    task automatic read_reg(input logic [4:0] addr, output logic [31:0] data);
        @(posedge clk);
        csr_address <= addr;
        csr_read    <= 1'b1;
        @(posedge clk);
        csr_read <= 1'b0;
        @(negedge clk);
        data = csr_readdata;
    endtask

    task automatic pulse_load(input int id);
        @(posedge clk);
        load_done <= 1'b1;
        load_core <= 2'(id);
        @(posedge clk);
        load_done <= 1'b0;
    endtask

    // counts the edges after the kick write until the request shows
    task automatic wait_request(input logic want_read, output int edges);
        edges = 0;
        @(negedge clk);
        while (!(want_read ? m0_read : m0_write) && edges < 8) begin
            @(negedge clk);
            edges++;
        end
        checks++;
        assert (want_read ? m0_read : m0_write)
        else begin
            errors++;
            $display("the m0 %s request was never raised", want_read ? "read" : "write");
        end
    endtask

    task automatic stretch_and_accept(input logic want_read, input int hold);
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            expect_equal("request held under waitrequest", want_read ? m0_read : m0_write, 1);
        end
        @(posedge clk);
        m0_waitrequest <= 1'b0;
        @(negedge clk);
        expect_equal("request before accepting edge", want_read ? m0_read : m0_write, 1);
        @(posedge clk); // accepting edge
        m0_waitrequest <= 1'b1;
        @(negedge clk);
        expect_equal("request after accepting edge", want_read ? m0_read : m0_write, 0);
    endtask

    task automatic readback_after_reset();
        logic [63:0] count;
        logic [3:0]  halt;
        logic [31:0] data;
        int          start;
        start = errors;
        count = 64'(rand_bits(64));
        halt  = 4'(rand_bits(4));
        @(posedge clk);
        src_counter <= count;
        core_halt   <= halt;
        read_reg(mspe_pkg::CSR_VERSION, data);
        expect_equal("version word", data, 32'h3434_0002);
        read_reg(mspe_pkg::CSR_CONTROL, data);
        expect_equal("control after reset", data, 0);
        read_reg(5'd1, data);
        expect_equal("unmapped address 1", data, 32'hDEAD_BEEF);
        for (int i = 0; i < 16; i++) begin
            read_reg(mspe_pkg::CSR_WINDOW_BASE + 5'(i), data);
            expect_equal("window slice after reset", data, 32'hFFFF_FFFF);
        end
        read_reg(mspe_pkg::CSR_SRC_COUNT_HI, data);
        expect_equal("counter high half", data, count[63:32]);
        read_reg(mspe_pkg::CSR_SRC_COUNT_LO, data);
        expect_equal("counter low half", data, count[31:0]);
        read_reg(mspe_pkg::CSR_STATUS, data);
        expect_equal("halt status", data, {28'd0, halt});
        @(posedge clk);
        core_halt <= '0;
        finish_test("readback_after_reset", start);
    endtask

    task automatic dram_write();
        logic [63:0]   addr;
        logic [DW-1:0] word;
        logic [31:0]   slice;
        int            edges;
        int            seen;
        int            start;
        start = errors;
        addr  = 64'(rand_bits(64));
        word  = '0;
        write_reg(mspe_pkg::CSR_DRAM_ADDR_HI, addr[63:32]);
        write_reg(mspe_pkg::CSR_DRAM_ADDR_LO, addr[31:0]);
        for (int i = 0; i < 16; i++) begin
            slice = 32'(rand_bits(32));
            word[(15 - i)*32 +: 32] = slice; // lowest address is the top slice
            write_reg(mspe_pkg::CSR_WINDOW_BASE + 5'(i), slice);
        end
        write_reg(mspe_pkg::CSR_DRAM_KICK, 32'd1);
        wait_request(1'b0, edges);
        expect_equal("edges from kick to m0_write", edges, 2);
        expect_equal("m0_address", m0_address, addr);
        expect_equal("m0_writedata", m0_writedata, word);
        expect_equal("m0_burstcount", m0_burstcount, 1);
        expect_equal("m0_byteenable", m0_byteenable, {64{1'b1}});
        expect_equal("m0_debugaccess", m0_debugaccess, 0);
        stretch_and_accept(1'b0, 1 + int'(rand_bits(3)));
        write_reg(mspe_pkg::CSR_DRAM_KICK, 32'd1); // same value again
        seen = 0;
        repeat (8) begin
            @(negedge clk);
            if (m0_write)
                seen++;
        end
        expect_equal("second write from repeated kick", seen, 0);
        finish_test("dram_write", start);
    endtask

    task automatic dram_read();
        logic [DW-1:0] word;
        logic [31:0]   data;
        int            edges;
        int            start;
        start = errors;
        write_reg(mspe_pkg::CSR_DRAM_KICK, 32'd0); // re-arm
        write_reg(mspe_pkg::CSR_DRAM_KICK, 32'd2);
        wait_request(1'b1, edges);
        expect_equal("edges from kick to m0_read", edges, 2);
        stretch_and_accept(1'b1, 1 + int'(rand_bits(2)));
        word = rand_bits(DW);
        @(posedge clk);
        m0_readdata      <= word;
        m0_readdatavalid <= 1'b1;
        @(posedge clk);
        m0_readdatavalid <= 1'b0;
        for (int i = 0; i < 16; i++) begin
            read_reg(mspe_pkg::CSR_WINDOW_BASE + 5'(i), data);
            expect_equal("read window slice", data, word[(15 - i)*32 +: 32]);
        end
        finish_test("dram_read", start);
    endtask

    task automatic in_order_sequencing();
        logic [DW-1:0] data2;
        logic [DW-1:0] data0;
        int            start;
        start = errors;
        data2 = rand_bits(DW);
        data0 = rand_bits(DW);
        clear_counts();
        pulse_load(2);
        pulse_load(0);
        idle(3);
        expect_equal("run pulses core 2", run_count[2], 1);
        expect_equal("run pulses core 0", run_count[0], 1);
        expect_equal("run pulses cores 1 and 3", run_count[1] + run_count[3], 0);
        core_halt[0] <= 1'b1; // core 0 is not at the head yet
        idle(5);
        expect_equal("requests before head halts", req_count.sum(), 0);
        core_halt[2]                <= 1'b1;
        core_src_valid[2]           <= 1'b1;
        core_src_sop[2]             <= 1'b1;
        core_src_data[2*DW +: DW]   <= data2;
        core_src_valid[0]           <= 1'b1;
        core_src_data[0 +: DW]      <= data0;
        @(negedge clk);
        expect_equal("src_valid from core 2", src_valid, 1);
        expect_equal("src_sop from core 2", src_sop, 1);
        expect_equal("src_data from core 2", src_data, data2);
        idle(5);
        expect_equal("requests to core 2", req_count[2], 1);
        expect_equal("requests to other cores", req_count.sum() - req_count[2], 0);
        clear_counts();
        core_src_sop[2] <= 1'b0;
        core_src_eop[2] <= 1'b1;
        @(negedge clk);
        expect_equal("src_eop from core 2", src_eop, 1);
        idle(5);
        core_src_eop[2]   <= 1'b0;
        core_src_valid[2] <= 1'b0;
        core_halt[2]      <= 1'b0;
        expect_equal("reset pulses core 2", rst_count[2], 1);
        expect_equal("reset pulses other cores", rst_count.sum() - rst_count[2], 0);
        expect_equal("requests to core 0 after release", req_count[0], 1);
        @(negedge clk);
        expect_equal("src_data from core 0", src_data, data0);
        expect_equal("src_valid from core 0", src_valid, 1);
        @(posedge clk);
        clear_counts();
        core_src_eop[0] <= 1'b1;
        idle(4);
        expect_equal("reset pulses core 0", rst_count[0], 1);
        @(negedge clk);
        expect_equal("src_valid with empty queue", src_valid, 0);
        expect_equal("src_data with empty queue", src_data, 0);
        @(posedge clk);
        core_src_eop[0]   <= 1'b0;
        core_src_valid[0] <= 1'b0;
        core_halt[0]      <= 1'b0;
        finish_test("in_order_sequencing", start);
    endtask

    task automatic control_register();
        logic [DW-1:0] data1;
        logic [31:0]   data;
        int            start;
        start = errors;
        data1 = rand_bits(DW);
        write_reg(mspe_pkg::CSR_CONTROL, 32'h9);
        idle(2);
        @(negedge clk);
        expect_equal("src_clear set", src_clear, 1);
        expect_equal("core_reset held", core_reset, 4'hF);
        clear_counts();
        pulse_load(1);
        core_src_valid[1]         <= 1'b1;
        core_src_data[1*DW +: DW] <= data1;
        idle(3);
        @(negedge clk);
        expect_equal("run pulse while held", run_count[1], 0);
        expect_equal("src_valid while held", src_valid, 0);
        expect_equal("src_data while held", src_data, 0);
        expect_equal("core_reset still held", core_reset, 4'hF);
        read_reg(mspe_pkg::CSR_CONTROL, data);
        expect_equal("control readback", data, 32'h9);
        write_reg(mspe_pkg::CSR_CONTROL, 32'h0);
        idle(2);
        @(negedge clk);
        expect_equal("src_clear cleared", src_clear, 0);
        expect_equal("core_reset released", core_reset, 0);
        clear_counts();
        pulse_load(1);
        idle(2);
        expect_equal("run pulse after release", run_count[1], 1);
        core_halt[1] <= 1'b1;
        @(negedge clk);
        expect_equal("src_data from core 1", src_data, data1);
        idle(4);
        expect_equal("requests to core 1", req_count[1], 1);
        core_src_eop[1] <= 1'b1;
        idle(4);
        expect_equal("reset pulses core 1", rst_count[1], 1);
        core_src_eop[1]   <= 1'b0;
        core_src_valid[1] <= 1'b0;
        core_halt[1]      <= 1'b0;
        read_reg(mspe_pkg::CSR_CONTROL, data);
        expect_equal("control readback cleared", data, 0);
        finish_test("control_register", start);
    endtask

    initial begin
        lfsr_state       = 32'h951f;
        reset            = 1'b1;
        csr_address      = '0;
        csr_writedata    = '0;
        csr_write        = 1'b0;
        csr_read         = 1'b0;
        m0_waitrequest   = 1'b1;
        m0_readdata      = '0;
        m0_readdatavalid = 1'b0;
        src_counter      = '0;
        load_done        = 1'b0;
        load_core        = '0;
        core_halt        = '0;
        core_src_valid   = '0;
        core_src_sop     = '0;
        core_src_eop     = '0;
        core_src_data    = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        readback_after_reset();
        dram_write();
        dram_read();
        in_order_sequencing();
        control_register();
        $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
src/mspe_pkg.sv
src/mspe_csr.sv
src/mspe_dram_bridge.sv
src/mspe_core_queue.sv
src/mspe_core_sequencer.sv
src/mspe_top.sv
verif/tb_mspe.sv

// ==== Bender.yml ====
package:
  name: mspe

sources:
  - src/mspe_pkg.sv
  - src/mspe_csr.sv
  - src/mspe_dram_bridge.sv
  - src/mspe_core_queue.sv
  - src/mspe_core_sequencer.sv
  - src/mspe_top.sv
  - target: test
    files:
      - verif/tb_mspe.sv
